//--- design/rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// Buffer geometry
`define ROB_ENTRIES 16
`define ROB_IDX_W 4

// Register name widths
`define ARCH_REG_W 5
`define PHYS_REG_W 6

// Number of rename source lookups per cycle
`define NUM_SOURCES 2

// Rename stays stalled this long after a nuke before the walk begins
`define RR_QUIESCE_CYCLES 5

`endif

//--- design/rob_pkg.sv
`include "rob_consts.svh"

package rob_pkg;

   typedef logic [`ROB_IDX_W-1:0]  t_rob_idx;
   typedef logic [`ARCH_REG_W-1:0] t_arch_reg;
   typedef logic [`PHYS_REG_W-1:0] t_phys_reg;

   // Wrap bit toggles each time the pointer passes the last slot
   typedef struct packed {
      logic     wrap;
      t_rob_idx idx;
   } t_rob_id;

   // Micro-op fields the buffer needs for retire and restore
   typedef struct packed {
      logic      has_dst;
      t_arch_reg dst;
      t_phys_reg pdst_old;
   } t_rob_uop;

   typedef struct packed {
      logic    valid;
      t_rob_id robid;
      logic    flush_needed;
      logic    is_mispred;
   } t_rob_complete_pkt;

   typedef struct packed {
      logic     valid;
      logic     ready;
      logic     flush_needed;
      logic     is_mispred;
      t_rob_uop uop;
   } t_rob_ent;

   typedef struct packed {
      logic      valid;
      t_phys_reg prfid;
   } t_reclaim_pkt;

   typedef struct packed {
      logic      valid;
      t_arch_reg gpr;
      t_phys_reg prfid;
   } t_restore_pkt;

   typedef enum logic {
      NUKE_BR_MISPRED,
      NUKE_EXCEPTION
   } t_nuke_type;

   typedef struct packed {
      logic       valid;
      t_nuke_type nuke_type;
   } t_nuke_pkt;

   typedef enum logic [1:0] {
      RR_IDLE,
      RR_QUIET,
      RR_WALK,
      RR_RESUME
   } t_rr_state;

   function automatic t_rob_id f_incr_robid(input t_rob_id id);
      return t_rob_id'(id + 1'b1);
   endfunction

   function automatic t_rob_id f_decr_robid(input t_rob_id id);
      return t_rob_id'(id - 1'b1);
   endfunction

endpackage

//--- design/rob_alloc_ctl.sv
`timescale 1ns/1ps

`include "rob_consts.svh"

module rob_alloc_ctl
   import rob_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    rob_alloc,
   input  logic                    retire_now,
   input  logic                    flush_now,
   input  t_rr_state               rr_state,
   output t_rob_id                 head_id,
   output t_rob_id                 tail_id,
   output logic                    rob_ready,
   output logic                    rob_empty,
   output logic [`ROB_ENTRIES-1:0] alloc_oh,
   output logic [`ROB_ENTRIES-1:0] retire_oh
);

   logic rob_full;

   // Oldest in-flight entry
   always_ff @(posedge clk) begin
      if (reset) begin
         head_id <= '0;
      end else if (retire_now) begin
         head_id <= f_incr_robid(head_id);
      end
   end

   // First free slot, pulled back to just past the flushing head on a nuke
   always_ff @(posedge clk) begin
      if (reset) begin
         tail_id <= '0;
      end else if (flush_now) begin
         tail_id <= f_incr_robid(head_id);
      end else if (rob_alloc) begin
         tail_id <= f_incr_robid(tail_id);
      end
   end

   // Same index, different lap means every slot is taken
   assign rob_empty = (head_id == tail_id);
   assign rob_full  = (head_id.idx == tail_id.idx) && (head_id.wrap != tail_id.wrap);

   // Rename is held off while full, during the nuke cycle and for the whole restore
   assign rob_ready = !rob_full && !flush_now && (rr_state == RR_IDLE);

   always_comb begin
      alloc_oh  = '0;
      retire_oh = '0;
      if (rob_alloc) begin
         alloc_oh = `ROB_ENTRIES'(1) << tail_id.idx;
      end
      if (retire_now) begin
         retire_oh = `ROB_ENTRIES'(1) << head_id.idx;
      end
   end

   // Rename must honour back-pressure
   a_alloc_only_when_ready: assert property (
      @(posedge clk) disable iff (reset)
      rob_alloc |-> rob_ready
   ) else $error("allocation while buffer not ready");

endmodule

//--- design/rob_entry.sv
`timescale 1ns/1ps

module rob_entry
   import rob_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  t_rob_id           slot_id,
   input  logic              alloc,
   input  t_rob_uop          alloc_uop,
   input  logic              retire,
   input  logic              flush_now,
   input  t_rob_id           head_id,
   input  t_rob_complete_pkt ex_complete,
   input  t_rob_complete_pkt mm_complete,
   output t_rob_ent          entry
);

   logic     valid;
   logic     ready;
   logic     flush_needed;
   logic     is_mispred;
   t_rob_uop uop;

   t_rob_id  my_id;
   logic     is_head;
   logic     ex_hit;
   logic     mm_hit;

   // Slots below the head index belong to the next lap
   assign my_id.idx  = slot_id.idx;
   assign my_id.wrap = (slot_id.idx >= head_id.idx) ? slot_id.wrap : ~slot_id.wrap;

   assign is_head = (slot_id.idx == head_id.idx);

   assign ex_hit = valid && ex_complete.valid && (ex_complete.robid == my_id);
   assign mm_hit = valid && mm_complete.valid && (mm_complete.robid == my_id);

   always_ff @(posedge clk) begin
      if (reset) begin
         valid        <= 1'b0;
         ready        <= 1'b0;
         flush_needed <= 1'b0;
         is_mispred   <= 1'b0;
      end else if (alloc) begin
         valid        <= 1'b1;
         ready        <= 1'b0;
         flush_needed <= 1'b0;
         is_mispred   <= 1'b0;
      end else if (retire || (flush_now && !is_head)) begin
         valid <= 1'b0;
      end else if (ex_hit) begin
         ready        <= 1'b1;
         flush_needed <= ex_complete.flush_needed;
         is_mispred   <= ex_complete.is_mispred;
      end else if (mm_hit) begin
         ready        <= 1'b1;
         flush_needed <= mm_complete.flush_needed;
         is_mispred   <= mm_complete.is_mispred;
      end
   end

   // Micro-op survives invalidation so the restore walk can still read it
   always_ff @(posedge clk) begin
      if (alloc) begin
         uop <= alloc_uop;
      end
   end

   assign entry.valid        = valid;
   assign entry.ready        = ready;
   assign entry.flush_needed = flush_needed;
   assign entry.is_mispred   = is_mispred;
   assign entry.uop          = uop;

   // Each id completes once, so both ports never name this slot together
   a_single_completion: assert property (
      @(posedge clk) disable iff (reset)
      !(ex_hit && mm_hit)
   ) else $error("slot %0d completed by both ports", slot_id.idx);

endmodule

//--- design/rob_retire_ctl.sv
`timescale 1ns/1ps

`include "rob_consts.svh"

module rob_retire_ctl
   import rob_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  t_rob_ent     entries [`ROB_ENTRIES-1:0],
   input  t_rob_id      head_id,
   input  t_rob_id      tail_id,
   input  logic         rob_empty,
   output logic         retire_now,
   output logic         flush_now,
   output t_rr_state    rr_state,
   output t_reclaim_pkt reclaim,
   output t_nuke_pkt    nuke,
   output t_restore_pkt restore,
   output logic         resume_fetch
);

   typedef logic [$clog2(`RR_QUIESCE_CYCLES + 1)-1:0] t_quiet_cnt;

   t_rob_ent   head_ent;
   t_rob_ent   walk_ent;
   t_rob_id    walk_id;
   t_quiet_cnt quiet_cnt;
   t_rr_state  rr_next;
   logic       walk_empty;

   assign head_ent = entries[head_id.idx];

   // A flushing head still retires and hands back its old register
   assign retire_now = !rob_empty && head_ent.valid && head_ent.ready;
   assign flush_now  = retire_now && head_ent.flush_needed;

   assign reclaim.valid = retire_now && head_ent.uop.has_dst;
   assign reclaim.prfid = head_ent.uop.pdst_old;

   assign nuke.valid     = flush_now;
   assign nuke.nuke_type = head_ent.is_mispred ? NUKE_BR_MISPRED : NUKE_EXCEPTION;

   // Nothing discarded when the walk pointer already sits on the flushing id
   assign walk_empty = (f_incr_robid(walk_id) == head_id);

   always_comb begin
      rr_next = rr_state;
      case (rr_state)
         RR_IDLE: begin
            if (flush_now) begin
               rr_next = RR_QUIET;
            end
         end
         RR_QUIET: begin
            if (quiet_cnt == '0) begin
               rr_next = walk_empty ? RR_RESUME : RR_WALK;
            end
         end
         RR_WALK: begin
            // Head now points at the oldest discarded entry
            if (walk_id == head_id) begin
               rr_next = RR_RESUME;
            end
         end
         RR_RESUME: begin
            rr_next = RR_IDLE;
         end
         default: begin
            rr_next = RR_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rr_state <= RR_IDLE;
      end else begin
         rr_state <= rr_next;
      end
   end

   // Counts down through the quiet period
   always_ff @(posedge clk) begin
      if (reset) begin
         quiet_cnt <= '0;
      end else if (flush_now) begin
         quiet_cnt <= t_quiet_cnt'(`RR_QUIESCE_CYCLES - 1);
      end else if ((rr_state == RR_QUIET) && (quiet_cnt != '0)) begin
         quiet_cnt <= quiet_cnt - 1'b1;
      end
   end

   // Youngest discarded entry first, stepping toward the flush point
   always_ff @(posedge clk) begin
      if (reset) begin
         walk_id <= '0;
      end else if (flush_now) begin
         walk_id <= f_decr_robid(tail_id);
      end else if (rr_state == RR_WALK) begin
         walk_id <= f_decr_robid(walk_id);
      end
   end

   assign walk_ent = entries[walk_id.idx];

   assign restore.valid = (rr_state == RR_WALK) && walk_ent.uop.has_dst;
   assign restore.gpr   = walk_ent.uop.dst;
   assign restore.prfid = walk_ent.uop.pdst_old;

   assign resume_fetch = (rr_state == RR_RESUME);

   // Completions from the ports must not flush a head while a restore runs
   a_nuke_only_idle: assert property (
      @(posedge clk) disable iff (reset)
      flush_now |-> (rr_state == RR_IDLE)
   ) else $error("nuke raised in restore state %s", rr_state.name());

endmodule

//--- design/rob_src_lookup.sv
`timescale 1ns/1ps

`include "rob_consts.svh"

module rob_src_lookup
   import rob_pkg::*;
(
   input  t_rob_ent  entries     [`ROB_ENTRIES-1:0],
   input  t_rob_id   head_id,
   input  t_arch_reg src_addr    [`NUM_SOURCES-1:0],
   output logic      src_pending [`NUM_SOURCES-1:0],
   output t_rob_id   src_robid   [`NUM_SOURCES-1:0]
);

   for (genvar s = 0; s < `NUM_SOURCES; s++) begin : g_src
      logic [`ROB_ENTRIES-1:0] match;
      t_rob_idx                youngest;

      // Valid entries that write this source register
      for (genvar i = 0; i < `ROB_ENTRIES; i++) begin : g_match
         assign match[i] = entries[i].valid
                        && entries[i].uop.has_dst
                        && (entries[i].uop.dst == src_addr[s]);
      end

      // Scan oldest to youngest from the head, so the last hit wins
      always_comb begin
         t_rob_idx scan_idx;
         youngest = head_id.idx;
         for (int k = 0; k < `ROB_ENTRIES; k++) begin
            scan_idx = head_id.idx + t_rob_idx'(k);
            if (match[scan_idx]) begin
               youngest = scan_idx;
            end
         end
      end

      assign src_pending[s] = |match;

      // Entries below the head index were allocated on the next lap
      assign src_robid[s].idx  = youngest;
      assign src_robid[s].wrap = (youngest >= head_id.idx) ? head_id.wrap : ~head_id.wrap;
   end

endmodule

//--- design/rob_top.sv
`timescale 1ns/1ps

`include "rob_consts.svh"

module rob_top
   import rob_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic              rob_alloc,
   input  t_rob_uop          alloc_uop,
   output logic              rob_ready,
   output t_rob_id           next_robid,
   output t_rob_id           oldest_robid,
   input  t_rob_complete_pkt ex_complete,
   input  t_rob_complete_pkt mm_complete,
   input  t_arch_reg         src_addr     [`NUM_SOURCES-1:0],
   output logic              src_pending  [`NUM_SOURCES-1:0],
   output t_rob_id           src_robid    [`NUM_SOURCES-1:0],
   output t_reclaim_pkt      reclaim,
   output t_nuke_pkt         nuke,
   output t_restore_pkt      restore,
   output logic              resume_fetch
);

   t_rob_id                 head_id;
   t_rob_id                 tail_id;
   logic                    rob_empty;
   logic                    retire_now;
   logic                    flush_now;
   t_rr_state               rr_state;
   logic [`ROB_ENTRIES-1:0] alloc_oh;
   logic [`ROB_ENTRIES-1:0] retire_oh;
   t_rob_ent                entries [`ROB_ENTRIES-1:0];

   assign next_robid   = tail_id;
   assign oldest_robid = head_id;

   rob_alloc_ctl i_alloc_ctl (
      .clk        (clk),
      .reset      (reset),
      .rob_alloc  (rob_alloc),
      .retire_now (retire_now),
      .flush_now  (flush_now),
      .rr_state   (rr_state),
      .head_id    (head_id),
      .tail_id    (tail_id),
      .rob_ready  (rob_ready),
      .rob_empty  (rob_empty),
      .alloc_oh   (alloc_oh),
      .retire_oh  (retire_oh)
   );

   for (genvar i = 0; i < `ROB_ENTRIES; i++) begin : g_entries
      t_rob_id slot_id;

      // Each slot resolves its own lap from the head wrap
      assign slot_id.wrap = head_id.wrap;
      assign slot_id.idx  = t_rob_idx'(i);

      rob_entry i_entry (
         .clk         (clk),
         .reset       (reset),
         .slot_id     (slot_id),
         .alloc       (alloc_oh[i]),
         .alloc_uop   (alloc_uop),
         .retire      (retire_oh[i]),
         .flush_now   (flush_now),
         .head_id     (head_id),
         .ex_complete (ex_complete),
         .mm_complete (mm_complete),
         .entry       (entries[i])
      );
   end

   rob_retire_ctl i_retire_ctl (
      .clk          (clk),
      .reset        (reset),
      .entries      (entries),
      .head_id      (head_id),
      .tail_id      (tail_id),
      .rob_empty    (rob_empty),
      .retire_now   (retire_now),
      .flush_now    (flush_now),
      .rr_state     (rr_state),
      .reclaim      (reclaim),
      .nuke         (nuke),
      .restore      (restore),
      .resume_fetch (resume_fetch)
   );

   rob_src_lookup i_src_lookup (
      .entries     (entries),
      .head_id     (head_id),
      .src_addr    (src_addr),
      .src_pending (src_pending),
      .src_robid   (src_robid)
   );

endmodule

//--- tests/rob_ref_model.svh
`ifndef ROB_REF_MODEL_SVH
`define ROB_REF_MODEL_SVH

typedef logic [`ROB_IDX_W:0] t_id_vec;

// One in-flight micro-op in program order
typedef struct packed {
   t_id_vec  id;
   t_rob_uop uop;
   logic     ready;
   logic     flush;
   logic     mispred;
} t_model_ent;

t_model_ent m_rob[$];
// Discarded micro-ops, youngest first
t_rob_uop   m_walk[$];
t_id_vec    m_stale[$];
t_id_vec    m_head;
t_id_vec    m_tail;
t_rr_state  m_rr;
int         m_quiet;

task automatic model_reset();
   m_rob.delete();
   m_walk.delete();
   m_stale.delete();
   m_head  = '0;
   m_tail  = '0;
   m_rr    = RR_IDLE;
   m_quiet = 0;
endtask

function automatic bit model_retiring();
   return (m_rob.size() > 0) && m_rob[0].ready;
endfunction

function automatic bit model_flushing();
   return model_retiring() && m_rob[0].flush;
endfunction

function automatic bit model_ready();
   return (m_rob.size() < `ROB_ENTRIES) && !model_flushing() && (m_rr == RR_IDLE);
endfunction

// Search from the young end so the first hit is the youngest producer
function automatic bit model_lookup(input t_arch_reg reg_num, output t_id_vec id);
   id = '0;
   for (int i = m_rob.size() - 1; i >= 0; i--) begin
      if (m_rob[i].uop.has_dst && (m_rob[i].uop.dst == reg_num)) begin
         id = m_rob[i].id;
         return 1'b1;
      end
   end
   return 1'b0;
endfunction

// Ids no longer in the list are simply dropped
task automatic model_complete(input t_rob_complete_pkt c);
   if (c.valid) begin
      foreach (m_rob[i]) begin
         if (m_rob[i].id == t_id_vec'(c.robid)) begin
            m_rob[i].ready   = 1'b1;
            m_rob[i].flush   = c.flush_needed;
            m_rob[i].mispred = c.is_mispred;
         end
      end
   end
endtask

// Advance the model across one rising edge
task automatic model_step(input logic alloc, input t_rob_uop uop,
                          input t_rob_complete_pkt ex, input t_rob_complete_pkt mm);
   t_rr_state  rr_now;
   bit         retire;
   bit         flush;
   t_model_ent ent;
   rr_now = m_rr;
   retire = model_retiring();
   flush  = model_flushing();
   model_complete(ex);
   model_complete(mm);
   if (flush) begin
      void'(m_rob.pop_front());
      m_walk.delete();
      m_stale.delete();
      while (m_rob.size() > 0) begin
         m_walk.push_front(m_rob[0].uop);
         m_stale.push_back(m_rob[0].id);
         void'(m_rob.pop_front());
      end
      m_head  = m_head + 1'b1;
      m_tail  = m_head;
      m_rr    = RR_QUIET;
      m_quiet = `RR_QUIESCE_CYCLES;
   end else if (retire) begin
      void'(m_rob.pop_front());
      m_head = m_head + 1'b1;
   end
   if (alloc) begin
      ent.id      = m_tail;
      ent.uop     = uop;
      ent.ready   = 1'b0;
      ent.flush   = 1'b0;
      ent.mispred = 1'b0;
      m_rob.push_back(ent);
      m_tail = m_tail + 1'b1;
   end
   case (rr_now)
      RR_QUIET: begin
         m_quiet--;
         if (m_quiet == 0) begin
            m_rr = (m_walk.size() > 0) ? RR_WALK : RR_RESUME;
         end
      end
      RR_WALK: begin
         void'(m_walk.pop_front());
         if (m_walk.size() == 0) begin
            m_rr = RR_RESUME;
         end
      end
      RR_RESUME: begin
         m_rr = RR_IDLE;
      end
      default: begin
      end
   endcase
endtask

`endif

//--- tests/rob_tb.sv
`timescale 1ns/1ps

`include "rob_consts.svh"

module rob_tb
   import rob_pkg::*;
();

   logic              clk;
   logic              reset;
   logic              rob_alloc;
   t_rob_uop          alloc_uop;
   logic              rob_ready;
   t_rob_id           next_robid;
   t_rob_id           oldest_robid;
   t_rob_complete_pkt ex_complete;
   t_rob_complete_pkt mm_complete;
   t_arch_reg         src_addr    [`NUM_SOURCES-1:0];
   logic              src_pending [`NUM_SOURCES-1:0];
   t_rob_id           src_robid   [`NUM_SOURCES-1:0];
   t_reclaim_pkt      reclaim;
   t_nuke_pkt         nuke;
   t_restore_pkt      restore;
   logic              resume_fetch;

   `include "rob_ref_model.svh"

   string test_name;
   int    test_errors;
   int    errors;
   int    tests_run;
   int    tests_failed;
   int    retire_count;
   int    lookup_hits;
   int    stale_sent;
   // Stimulus mix in percent, plus register range for lookup density
   int    alloc_pct;
   int    cmpl_pct;
   int    flush_pct;
   int    reg_range;
   bit    stale_en;
   bit    saw_nuke;
   bit    saw_resume;
   t_id_vec nuke_head;

   rob_top i_dut (
      .clk          (clk),
      .reset        (reset),
      .rob_alloc    (rob_alloc),
      .alloc_uop    (alloc_uop),
      .rob_ready    (rob_ready),
      .next_robid   (next_robid),
      .oldest_robid (oldest_robid),
      .ex_complete  (ex_complete),
      .mm_complete  (mm_complete),
      .src_addr     (src_addr),
      .src_pending  (src_pending),
      .src_robid    (src_robid),
      .reclaim      (reclaim),
      .nuke         (nuke),
      .restore      (restore),
      .resume_fetch (resume_fetch)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act) else begin
         $display("mismatch test=%s %s expected=%0h actual=%0h", test_name, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_true(input bit cond, input string what);
      assert (cond) else begin
         $display("error in test %s: %s", test_name, what);
         test_errors++;
      end
   endtask

   task automatic check_outputs();
      logic    pend;
      t_id_vec id;
      check_value("rob_ready", model_ready(), rob_ready);
      check_value("next_robid", m_tail, next_robid);
      check_value("oldest_robid", m_head, oldest_robid);
      if (model_retiring() && m_rob[0].uop.has_dst) begin
         check_value("reclaim.valid", 1, reclaim.valid);
         check_value("reclaim.prfid", m_rob[0].uop.pdst_old, reclaim.prfid);
      end else begin
         check_value("reclaim.valid", 0, reclaim.valid);
      end
      check_value("nuke.valid", model_flushing(), nuke.valid);
      if (model_flushing()) begin
         check_value("nuke.nuke_type",
                     m_rob[0].mispred ? NUKE_BR_MISPRED : NUKE_EXCEPTION, nuke.nuke_type);
      end
      if ((m_rr == RR_WALK) && m_walk[0].has_dst) begin
         check_value("restore.valid", 1, restore.valid);
         check_value("restore.gpr", m_walk[0].dst, restore.gpr);
         check_value("restore.prfid", m_walk[0].pdst_old, restore.prfid);
      end else begin
         check_value("restore.valid", 0, restore.valid);
      end
      check_value("resume_fetch", m_rr == RR_RESUME, resume_fetch);
      for (int s = 0; s < `NUM_SOURCES; s++) begin
         pend = model_lookup(src_addr[s], id);
         check_value($sformatf("src_pending[%0d]", s), pend, src_pending[s]);
         if (pend) begin
            check_value($sformatf("src_robid[%0d]", s), id, src_robid[s]);
            lookup_hits++;
         end
      end
   endtask

   task automatic drive_inputs();
      int                cand[$];
      int                pick;
      t_rob_uop          uop;
      t_rob_complete_pkt pkt [2];
      pkt[0] = '0;
      pkt[1] = '0;
      foreach (m_rob[i]) begin
         if (!m_rob[i].ready) begin
            cand.push_back(i);
         end
      end
      for (int p = 0; p < 2; p++) begin
         if (stale_en && (m_rr == RR_QUIET) && (m_stale.size() > 0)) begin
            // Ids from the last flush, already gone from the buffer
            pkt[p].valid        = 1'b1;
            pkt[p].robid        = t_rob_id'(m_stale.pop_front());
            pkt[p].flush_needed = $urandom_range(1);
            pkt[p].is_mispred   = $urandom_range(1);
            stale_sent++;
         end else if ((cand.size() > 0) && ($urandom_range(99) < cmpl_pct)) begin
            pick                = $urandom_range(cand.size() - 1);
            pkt[p].valid        = 1'b1;
            pkt[p].robid        = t_rob_id'(m_rob[cand[pick]].id);
            pkt[p].flush_needed = ($urandom_range(99) < flush_pct);
            pkt[p].is_mispred   = $urandom_range(1);
            cand.delete(pick);
         end
      end
      uop.has_dst  = ($urandom_range(3) != 0);
      uop.dst      = t_arch_reg'($urandom_range(reg_range - 1));
      uop.pdst_old = t_phys_reg'($urandom);
      rob_alloc   <= model_ready() && ($urandom_range(99) < alloc_pct);
      alloc_uop   <= uop;
      ex_complete <= pkt[0];
      mm_complete <= pkt[1];
      for (int s = 0; s < `NUM_SOURCES; s++) begin
         src_addr[s] <= t_arch_reg'($urandom_range(reg_range - 1));
      end
   endtask

   // Drive on the rising edge, compare at the falling edge, then step the model
   task automatic step();
      @(posedge clk);
      drive_inputs();
      @(negedge clk);
      check_outputs();
      saw_nuke   = model_flushing();
      saw_resume = (m_rr == RR_RESUME);
      if (saw_nuke) begin
         nuke_head = m_head;
      end
      if (model_retiring()) begin
         retire_count++;
      end
      model_step(rob_alloc, alloc_uop, ex_complete, mm_complete);
   endtask

   function automatic bit goal_reached(input string goal);
      case (goal)
         "full":    return m_rob.size() == `ROB_ENTRIES;
         "half":    return m_rob.size() >= (`ROB_ENTRIES / 2);
         "drained": return (m_rob.size() == 0) && (m_rr == RR_IDLE);
         "nuke":    return saw_nuke;
         "resume":  return saw_resume;
         default:   return 1'b0;
      endcase
   endfunction

   task automatic wait_for(input string goal, input int limit);
      int n;
      n          = 0;
      saw_nuke   = 1'b0;
      saw_resume = 1'b0;
      while (!goal_reached(goal) && (n < limit)) begin
         step();
         n++;
      end
      check_true(goal_reached(goal),
                 $sformatf("timed out after %0d cycles waiting for %s", limit, goal));
   endtask

   task automatic set_knobs(input int a, input int c, input int f, input int r);
      alloc_pct = a;
      cmpl_pct  = c;
      flush_pct = f;
      reg_range = r;
   endtask

   task automatic begin_test(input string name);
      test_name    = name;
      test_errors  = 0;
      retire_count = 0;
      lookup_hits  = 0;
      stale_sent   = 0;
   endtask

   task automatic end_test();
      tests_run++;
      errors += test_errors;
      if (test_errors == 0) begin
         $display("test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", test_name, test_errors);
      end
   endtask

   task automatic test_alloc_ids();
      begin_test("alloc_ids");
      set_knobs(100, 0, 0, 32);
      wait_for("full", 40);
      step();
      check_value("rob_ready when full", 0, rob_ready);
      check_value("next_robid when full", `ROB_ENTRIES, next_robid);
      set_knobs(0, 100, 0, 32);
      wait_for("drained", 100);
      // Keep allocating and retiring so the tail passes the id wrap
      set_knobs(100, 100, 0, 32);
      repeat (80) step();
      set_knobs(0, 100, 0, 32);
      wait_for("drained", 100);
      end_test();
   endtask

   task automatic test_in_order_retire();
      begin_test("in_order_retire");
      set_knobs(60, 40, 0, 32);
      repeat (400) step();
      set_knobs(0, 100, 0, 32);
      wait_for("drained", 100);
      check_true(retire_count > 0, "no entry retired");
      end_test();
   endtask

   task automatic test_flush_restore();
      begin_test("flush_restore");
      for (int k = 0; k < 4; k++) begin
         set_knobs(60, 40, 15, 32);
         wait_for("nuke", 2000);
         wait_for("resume", 64);
         check_value("next_robid after resume", t_id_vec'(nuke_head + 1'b1), next_robid);
         step();
         check_value("rob_ready after resume", 1, rob_ready);
      end
      set_knobs(0, 100, 0, 32);
      wait_for("drained", 400);
      end_test();
   endtask

   task automatic test_src_lookup();
      begin_test("src_lookup");
      set_knobs(70, 35, 0, 4);
      repeat (300) step();
      set_knobs(0, 100, 0, 4);
      wait_for("drained", 100);
      check_true(lookup_hits > 0, "no lookup ever found a producer");
      end_test();
   endtask

   task automatic test_stale_completion();
      begin_test("stale_completion");
      set_knobs(100, 0, 0, 32);
      wait_for("half", 40);
      // Two random entries get a flush request, the older one nukes
      set_knobs(0, 100, 100, 32);
      step();
      set_knobs(0, 100, 0, 32);
      stale_en = 1'b1;
      wait_for("nuke", 100);
      wait_for("resume", 64);
      stale_en = 1'b0;
      check_true(stale_sent > 0, "no completion was sent to a discarded id");
      set_knobs(60, 40, 0, 32);
      repeat (200) step();
      set_knobs(0, 100, 0, 32);
      wait_for("drained", 100);
      end_test();
   endtask

   initial begin
      void'($urandom(64));
      reset       = 1'b1;
      rob_alloc   = 1'b0;
      alloc_uop   = '0;
      ex_complete = '0;
      mm_complete = '0;
      for (int s = 0; s < `NUM_SOURCES; s++) begin
         src_addr[s] = '0;
      end
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      stale_en     = 1'b0;
      set_knobs(0, 0, 0, 32);
      model_reset();
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      test_alloc_ids();
      test_in_order_retire();
      test_flush_restore();
      test_src_lookup();
      test_stale_completion();
      $display("summary: %0d tests run, %0d failing, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- all.f
+incdir+design
+incdir+tests
design/rob_pkg.sv
design/rob_alloc_ctl.sv
design/rob_entry.sv
design/rob_retire_ctl.sv
design/rob_src_lookup.sv
design/rob_top.sv
tests/rob_tb.sv
